// File: hdl/axi_pkg.sv
// ******************************
// AXI4 types for a single-beat master and slave. Only ID zero is used,
// so the channels carry no ID field. Lock, cache, QoS and region are
// left out, and every transfer is one beat of the full bus width.
// ******************************
package axi_pkg;

  localparam int axi_addr_width_lp = 32;
  localparam int axi_data_width_lp = 64;
  localparam int axi_strb_width_lp = axi_data_width_lp / 8;

  localparam logic [2:0] axi_size_lp       = 3'($clog2(axi_strb_width_lp)); // Full word.
  localparam logic [7:0] axi_len_single_lp = 8'd0;  // One beat per burst.
  localparam logic [1:0] axi_burst_incr_lp = 2'b01;
  localparam logic [2:0] axi_prot_lp       = 3'b000; // Data, secure, unprivileged.

  typedef enum logic [1:0] {
    axi_resp_okay   = 2'b00,
    axi_resp_exokay = 2'b01,
    axi_resp_slverr = 2'b10,
    axi_resp_decerr = 2'b11
  } axi_resp_e;

  // Address channel, shared layout for writes and reads.
  typedef struct packed {
    logic [axi_addr_width_lp-1:0] addr;
    logic [2:0]                   size;
    logic [7:0]                   len;
    logic [1:0]                   burst;
    logic [2:0]                   prot;
  } axi_aw_t;

  typedef axi_aw_t axi_ar_t;

  typedef struct packed {
    logic [axi_data_width_lp-1:0] data;
    logic [axi_strb_width_lp-1:0] strb;
    logic                         last;
  } axi_w_t;

  typedef struct packed {
    axi_resp_e resp;
  } axi_b_t;

  typedef struct packed {
    logic [axi_data_width_lp-1:0] data;
    axi_resp_e                    resp;
    logic                         last;
  } axi_r_t;

endpackage

// File: hdl/axi_sram.sv
// ******************************
// Single-beat AXI4 slave over 256 words of 64 bits. Burst fields are
// ignored. Addresses at 2048 and above answer SLVERR; such writes are
// dropped and such reads return zero.
// ******************************
`timescale 1ns/1ps

module axi_sram (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic             aw_valid_i,
  input  axi_pkg::axi_aw_t aw_i,
  output logic             aw_ready_o,
  input  logic             w_valid_i,
  input  axi_pkg::axi_w_t  w_i,
  output logic             w_ready_o,
  output logic             b_valid_o,
  output axi_pkg::axi_b_t  b_o,
  input  logic             b_ready_i,
  input  logic             ar_valid_i,
  input  axi_pkg::axi_ar_t ar_i,
  output logic             ar_ready_o,
  output logic             r_valid_o,
  output axi_pkg::axi_r_t  r_o,
  input  logic             r_ready_i
);

  import axi_pkg::*;
  import mem_req_pkg::*;

  logic [mem_data_width_lp-1:0]  mem_q [mem_words_lp];
  logic                          write_fire, read_fire;
  logic                          w_in_range, r_in_range;
  logic [mem_index_width_lp-1:0] w_index, r_index;
  logic                          b_valid_q, r_valid_q;
  axi_b_t                        b_q;
  axi_r_t                        r_q;

  // ******************************
  // Handshakes
  // ******************************
  // A write needs address and data together and a free response slot.
  assign aw_ready_o = w_valid_i & ~b_valid_q;
  assign w_ready_o  = aw_valid_i & ~b_valid_q;
  assign write_fire = aw_valid_i & w_valid_i & ~b_valid_q;
  assign ar_ready_o = ~r_valid_q;  // No read is pending.
  assign read_fire  = ar_valid_i & ar_ready_o;

  assign w_in_range = aw_i.addr < axi_addr_width_lp'(mem_bytes_lp);
  assign r_in_range = ar_i.addr < axi_addr_width_lp'(mem_bytes_lp);
  assign w_index    = aw_i.addr[mem_byte_lsb_lp +: mem_index_width_lp];
  assign r_index    = ar_i.addr[mem_byte_lsb_lp +: mem_index_width_lp];

  // Byte-enabled write into the array.
  always_ff @(posedge clk_i) begin
    if (write_fire && w_in_range) begin
      for (int i = 0; i < mem_strb_width_lp; i++) begin
        if (w_i.strb[i]) begin
          mem_q[w_index][i*8 +: 8] <= w_i.data[i*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      if (write_fire) begin
        b_valid_q <= 1'b1;
      end else if (b_ready_i) begin
        b_valid_q <= 1'b0;
      end
      if (read_fire) begin
        r_valid_q <= 1'b1;
      end else if (r_ready_i) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  // Response payloads, loaded at the accept.
  always_ff @(posedge clk_i) begin
    if (write_fire) begin
      b_q.resp <= w_in_range ? axi_resp_okay : axi_resp_slverr;
    end
    if (read_fire) begin
      r_q.data <= r_in_range ? mem_q[r_index] : '0;
      r_q.resp <= r_in_range ? axi_resp_okay : axi_resp_slverr;
      r_q.last <= 1'b1;
    end
  end

  assign b_valid_o = b_valid_q;
  assign b_o       = b_q;
  assign r_valid_o = r_valid_q;
  assign r_o       = r_q;

  // The master keeps an address beat steady until it is taken.
  a_aw_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    aw_valid_i && !aw_ready_o |=> aw_valid_i && $stable(aw_i));

  a_ar_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ar_valid_i && !ar_ready_o |=> ar_valid_i && $stable(ar_i));

endmodule

// File: hdl/fifo_to_axi.sv
// ******************************
// Aligned requests to AXI4 single beats, one transaction outstanding so
// reads and writes complete in order. Read data is returned unshifted.
// ******************************
`timescale 1ns/1ps

module fifo_to_axi (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      aligned_valid_i,
  input  mem_req_pkg::mem_aligned_t aligned_i,
  output logic                      aligned_ready_o,
  output logic                      rsp_valid_o,
  output mem_req_pkg::mem_rsp_t     rsp_o,
  input  logic                      rsp_ready_i,
  output logic                      aw_valid_o,
  output axi_pkg::axi_aw_t          aw_o,
  input  logic                      aw_ready_i,
  output logic                      w_valid_o,
  output axi_pkg::axi_w_t           w_o,
  input  logic                      w_ready_i,
  input  logic                      b_valid_i,
  input  axi_pkg::axi_b_t           b_i,
  output logic                      b_ready_o,
  output logic                      ar_valid_o,
  output axi_pkg::axi_ar_t          ar_o,
  input  logic                      ar_ready_i,
  input  logic                      r_valid_i,
  input  axi_pkg::axi_r_t           r_i,
  output logic                      r_ready_o
);

  import axi_pkg::*;

  typedef struct packed {
    logic                         write;
    logic [axi_addr_width_lp-1:0] addr;
  } addr_slot_t;

  addr_slot_t addr_d;
  addr_slot_t addr_q;
  axi_w_t     wdata_d;
  axi_aw_t    ax;        // Common address beat for aw and ar.
  logic       accept;
  logic       addr_ready, addr_valid, addr_taken;
  logic       wdata_ready;
  logic       ret_ready, ret_valid, ret_write;

  // A request enters only when all three slots are empty.
  assign aligned_ready_o = addr_ready & wdata_ready & ret_ready;
  assign accept          = aligned_valid_i & aligned_ready_o;

  assign addr_d.write = aligned_i.write;
  assign addr_d.addr  = aligned_i.addr;
  assign wdata_d.data = aligned_i.data;
  assign wdata_d.strb = aligned_i.strb;
  assign wdata_d.last = 1'b1;

  one_slot_buffer #(.payload_t(addr_slot_t)) addr_slot (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .valid_i(accept), .data_i(addr_d), .ready_o(addr_ready),
    .valid_o(addr_valid), .data_o(addr_q), .ready_i(addr_taken)
  );

  one_slot_buffer #(.payload_t(axi_w_t)) wdata_slot (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .valid_i(accept & aligned_i.write), .data_i(wdata_d), .ready_o(wdata_ready),
    .valid_o(w_valid_o), .data_o(w_o), .ready_i(w_ready_i)
  );

  // Remembers the kind of the transaction in flight.
  one_slot_buffer #(.payload_t(logic)) ret_slot (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .valid_i(accept), .data_i(aligned_i.write), .ready_o(ret_ready),
    .valid_o(ret_valid), .data_o(ret_write), .ready_i(rsp_valid_o & rsp_ready_i)
  );

  // ******************************
  // Address steering
  // ******************************
  assign ax.addr  = addr_q.addr;
  assign ax.size  = axi_size_lp;
  assign ax.len   = axi_len_single_lp;
  assign ax.burst = axi_burst_incr_lp;
  assign ax.prot  = axi_prot_lp;

  assign aw_o       = ax;
  assign ar_o       = ax;
  assign aw_valid_o = addr_valid & addr_q.write;
  assign ar_valid_o = addr_valid & ~addr_q.write;
  assign addr_taken = (aw_valid_o & aw_ready_i) | (ar_valid_o & ar_ready_i);

  // Response path, selected by the return slot.
  assign rsp_valid_o = ret_valid & (ret_write ? b_valid_i : r_valid_i);
  assign rsp_o.write = ret_write;
  assign rsp_o.data  = ret_write ? '0 : r_i.data;
  assign rsp_o.error = ret_write ? (b_i.resp != axi_resp_okay) : (r_i.resp != axi_resp_okay);
  assign b_ready_o   = ret_valid & ret_write & rsp_ready_i;
  assign r_ready_o   = ret_valid & ~ret_write & rsp_ready_i;

  a_r_for_read: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    r_valid_i |-> ret_valid && !ret_write);

  a_b_for_write: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    b_valid_i |-> ret_valid && ret_write);

endmodule

// File: hdl/mem_axi_top.sv
// ******************************
// Request port to AXI4 memory: align stage, bridge and slave memory.
// One transaction is in flight at a time.
// ******************************
`timescale 1ns/1ps

module mem_axi_top (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  req_valid_i,
  input  mem_req_pkg::mem_req_t req_i,
  output logic                  req_ready_o,
  output logic                  rsp_valid_o,
  output mem_req_pkg::mem_rsp_t rsp_o,
  input  logic                  rsp_ready_i
);

  import axi_pkg::*;
  import mem_req_pkg::*;

  mem_aligned_t aligned;
  logic         aligned_valid, aligned_ready;

  // AXI channels between the bridge and the memory.
  axi_aw_t aw;
  axi_w_t  w;
  axi_b_t  b;
  axi_ar_t ar;
  axi_r_t  r;
  logic    aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
  logic    ar_valid, ar_ready, r_valid, r_ready;

  req_lane_align req_lane_align_inst (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .req_valid_i(req_valid_i), .req_i(req_i), .req_ready_o(req_ready_o),
    .aligned_valid_o(aligned_valid), .aligned_o(aligned), .aligned_ready_i(aligned_ready)
  );

  fifo_to_axi fifo_to_axi_inst (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .aligned_valid_i(aligned_valid), .aligned_i(aligned), .aligned_ready_o(aligned_ready),
    .rsp_valid_o(rsp_valid_o), .rsp_o(rsp_o), .rsp_ready_i(rsp_ready_i),
    .aw_valid_o(aw_valid), .aw_o(aw), .aw_ready_i(aw_ready),
    .w_valid_o(w_valid), .w_o(w), .w_ready_i(w_ready),
    .b_valid_i(b_valid), .b_i(b), .b_ready_o(b_ready),
    .ar_valid_o(ar_valid), .ar_o(ar), .ar_ready_i(ar_ready),
    .r_valid_i(r_valid), .r_i(r), .r_ready_o(r_ready)
  );

  axi_sram axi_sram_inst (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .aw_valid_i(aw_valid), .aw_i(aw), .aw_ready_o(aw_ready),
    .w_valid_i(w_valid), .w_i(w), .w_ready_o(w_ready),
    .b_valid_o(b_valid), .b_o(b), .b_ready_i(b_ready),
    .ar_valid_i(ar_valid), .ar_i(ar), .ar_ready_o(ar_ready),
    .r_valid_o(r_valid), .r_o(r), .r_ready_i(r_ready)
  );

endmodule

// File: hdl/mem_req_pkg.sv
// ******************************
// Request, response and memory geometry for the bridge. The size field
// is log2 of the byte count and never exceeds 3.
// ******************************
package mem_req_pkg;

  localparam int mem_addr_width_lp  = 32;
  localparam int mem_data_width_lp  = 64;
  localparam int mem_strb_width_lp  = mem_data_width_lp / 8;
  localparam int mem_words_lp       = 256;
  localparam int mem_byte_lsb_lp    = $clog2(mem_strb_width_lp); // Byte offset bits.
  localparam int mem_index_width_lp = $clog2(mem_words_lp);
  localparam int mem_bytes_lp       = mem_words_lp * mem_strb_width_lp; // First bad address.

  // Request as it arrives from the outside.
  typedef struct packed {
    logic                         write;
    logic [mem_addr_width_lp-1:0] addr;
    logic [2:0]                   size;
    logic [mem_data_width_lp-1:0] data;
  } mem_req_t;

  // Request after lane alignment, ready for a single AXI beat.
  typedef struct packed {
    logic                         write;
    logic [mem_addr_width_lp-1:0] addr;
    logic [mem_strb_width_lp-1:0] strb;
    logic [mem_data_width_lp-1:0] data;
  } mem_aligned_t;

  typedef struct packed {
    logic                         write;
    logic [mem_data_width_lp-1:0] data;  // Zero for writes.
    logic                         error;
  } mem_rsp_t;

endpackage

// File: hdl/one_slot_buffer.sv
// ******************************
// One-entry valid/ready buffer. It takes new data only when empty, so
// throughput is one transfer every two cycles at best.
// ******************************
`timescale 1ns/1ps

module one_slot_buffer #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     valid_i,
  input  payload_t data_i,
  output logic     ready_o,
  output logic     valid_o,
  output payload_t data_o,
  input  logic     ready_i
);

  logic     full_q;
  payload_t data_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      full_q <= 1'b0;
    end else if (valid_i && ready_o) begin
      full_q <= 1'b1;
    end else if (valid_o && ready_i) begin
      full_q <= 1'b0; // Drained by the consumer.
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;
    end
  end

  assign ready_o = ~full_q;  // Ready means empty.
  assign valid_o = full_q;
  assign data_o  = data_q;

  // The source keeps its payload until the buffer takes it.
  a_source_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    valid_i && !ready_o |=> valid_i && $stable(data_i));

endmodule

// File: hdl/req_lane_align.sv
// ******************************
// Turns a request into a strobe and replicated write data. A size above
// 3 is treated as a full word. Adds one cycle of latency.
// ******************************
`timescale 1ns/1ps

module req_lane_align (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      req_valid_i,
  input  mem_req_pkg::mem_req_t     req_i,
  output logic                      req_ready_o,
  output logic                      aligned_valid_o,
  output mem_req_pkg::mem_aligned_t aligned_o,
  input  logic                      aligned_ready_i
);

  import mem_req_pkg::*;

  mem_aligned_t                 aligned_d;
  logic [mem_strb_width_lp-1:0] size_mask;   // Ones for the bytes of one access.
  logic [mem_byte_lsb_lp-1:0]   addr_mask;   // Address bits below the size.
  logic [mem_byte_lsb_lp-1:0]   byte_offset;

  // ******************************
  // Lane decode
  // ******************************
  always_comb begin
    case (req_i.size)
      3'd0: begin
        size_mask      = 8'h01;
        addr_mask      = 3'b000;
        aligned_d.data = {8{req_i.data[7:0]}};
      end
      3'd1: begin
        size_mask      = 8'h03;
        addr_mask      = 3'b001;
        aligned_d.data = {4{req_i.data[15:0]}};
      end
      3'd2: begin
        size_mask      = 8'h0f;
        addr_mask      = 3'b011;
        aligned_d.data = {2{req_i.data[31:0]}};
      end
      default: begin
        size_mask      = 8'hff;
        addr_mask      = 3'b111;
        aligned_d.data = req_i.data;
      end
    endcase
  end

  // The offset is taken after alignment, so the strobe never wraps.
  assign byte_offset     = req_i.addr[mem_byte_lsb_lp-1:0] & ~addr_mask;
  assign aligned_d.write = req_i.write;
  assign aligned_d.addr  = {req_i.addr[mem_addr_width_lp-1:mem_byte_lsb_lp], byte_offset};
  assign aligned_d.strb  = size_mask << byte_offset;

  one_slot_buffer #(
    .payload_t(mem_aligned_t)
  ) align_slot (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .valid_i (req_valid_i),
    .data_i  (aligned_d),
    .ready_o (req_ready_o),
    .valid_o (aligned_valid_o),
    .data_o  (aligned_o),
    .ready_i (aligned_ready_i)
  );

endmodule

// File: mem_axi.f
hdl/axi_pkg.sv
hdl/mem_req_pkg.sv
hdl/one_slot_buffer.sv
hdl/req_lane_align.sv
hdl/fifo_to_axi.sv
hdl/axi_sram.sv
hdl/mem_axi_top.sv
testbench/mem_axi_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compiles the testbench with Verilator, runs it, and decides the result
# from the simulation log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=mem_axi_sim

verilator --binary --timing --assert -Wno-fatal \
  -f mem_axi.f --top-module mem_axi_tb \
  --Mdir "$OBJ" -o "$BIN"
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "sim passed" "$LOG"; then
  echo "Result: PASS"
  exit 0
else
  echo "Result: FAIL"
  exit 1
fi

// File: testbench/mem_axi_tb.sv
// ******************************
// Table-driven testbench for mem_axi_top with a reference memory model.
// Every memory word is preloaded first, because the DUT memory powers up
// unknown. Responses are checked in order, one per accepted request.
// ******************************
`timescale 1ns/1ps

module mem_axi_tb;

  import mem_req_pkg::*;

  localparam int wait_limit_lp  = 200; // Cycles allowed for any single wait.
  localparam int random_reqs_lp = 200;

  typedef struct packed {
    mem_req_t req;
    logic     stall;  // Hold the response port low for a few cycles.
  } stim_t;

  logic     clk;
  logic     arst_n;
  logic     req_valid;
  mem_req_t req;
  logic     req_ready;
  logic     rsp_valid;
  mem_rsp_t rsp;
  logic     rsp_ready;

  logic [63:0] model_word [mem_words_lp];
  stim_t       stim_q [$];
  mem_rsp_t    exp_q [$];
  integer      seed;
  logic        random_phase;
  int          stall_cycles;
  int          sent_count;
  int          recv_count;
  int          value_errors;
  int          other_errors;

  mem_axi_top mem_axi_top_inst (
    .clk_i(clk), .arst_n_i(arst_n),
    .req_valid_i(req_valid), .req_i(req), .req_ready_o(req_ready),
    .rsp_valid_o(rsp_valid), .rsp_o(rsp), .rsp_ready_i(rsp_ready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ******************************
  // Compare tasks
  // ******************************
  task automatic check_rsp(input mem_rsp_t got, input mem_rsp_t exp, input string msg);
    if (got !== exp) begin
      value_errors++;
      $display("CHECK FAILED at %0t: %s got w=%0b d=%h e=%0b expected w=%0b d=%h e=%0b",
               $time, msg, got.write, got.data, got.error, exp.write, exp.data, exp.error);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string msg);
    if (got != exp) begin
      value_errors++;
      $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, msg, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string msg);
    if (got !== exp) begin
      value_errors++;
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, msg, got, exp);
    end
  endtask

  task automatic abort_run(input string what);
    other_errors++;
    $display("Run stopped at %0t because of a %s", $time, what);
    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    $display("sim failed");
    $finish;
  endtask

  // ******************************
  // Reference model and stimulus helpers
  // ******************************
  function automatic logic [63:0] fill_word(input logic [31:0] addr);
    return {addr, addr ^ 32'h5a5a_a5a5};
  endfunction

  function automatic mem_req_t make_req(input logic wr, input logic [31:0] addr,
                                        input logic [2:0] size, input logic [63:0] data);
    mem_req_t r;
    r.write = wr;
    r.addr  = addr;
    r.size  = size;
    r.data  = data;
    return r;
  endfunction

  task automatic add_stim(input logic wr, input logic [31:0] addr, input logic [2:0] size,
                          input logic [63:0] data, input logic stall);
    stim_t s;
    s.req   = make_req(wr, addr, size, data);
    s.stall = stall;
    stim_q.push_back(s);
  endtask

  // Byte count is 2^size; the access is aligned down and lands in lanes from the offset.
  task automatic apply_model(input mem_req_t r, output mem_rsp_t exp);
    int          nbytes;
    logic [31:0] base;
    int          idx;
    logic        in_range;
    nbytes    = 1 << ((r.size > 3'd3) ? 3 : int'(r.size));
    base      = r.addr & ~(32'(nbytes) - 32'd1);
    idx       = int'(base[10:3]);
    in_range  = base < 32'd2048;
    exp.write = r.write;
    exp.error = ~in_range;
    exp.data  = '0;
    if (r.write && in_range) begin
      for (int b = 0; b < nbytes; b++) begin
        model_word[idx][(int'(base[2:0]) + b) * 8 +: 8] = r.data[b * 8 +: 8];
      end
    end else if (!r.write && in_range) begin
      exp.data = model_word[idx];
    end
  endtask

  // Called 1 ns after a rising edge and returns at the same point of a later cycle.
  task automatic send_req(input mem_req_t r, input logic stall);
    mem_rsp_t exp;
    int       waited;
    waited    = 0;
    req_valid = 1'b1;
    req       = r;
    @(negedge clk);
    while (!req_ready) begin
      waited++;
      if (waited > wait_limit_lp) abort_run("timeout waiting for req_ready");
      @(negedge clk);
    end
    apply_model(r, exp);
    exp_q.push_back(exp);
    sent_count++;
    if (stall) stall_cycles = 6;
    @(posedge clk);
    #1;
    req_valid = 1'b0;
  endtask

  task automatic build_table();
    // Full word write, then read back.
    add_stim(1'b1, 32'h40, 3'd3, 64'h0123_4567_89ab_cdef, 1'b0);
    add_stim(1'b0, 32'h40, 3'd3, '0, 1'b1);
    // Sub-word writes at every legal offset, one word per size, then a full read.
    for (int s = 0; s < 3; s++) begin
      for (int off = 0; off < 8; off += (1 << s)) begin
        add_stim(1'b1, 32'h80 + 32'(s * 8 + off), 3'(s),
                 64'hf0e1_d2c3_b4a5_9687 + 64'(s * 16 + off), 1'(off == 2));
      end
      add_stim(1'b0, 32'h80 + 32'(s * 8), 3'd3, '0, 1'b0);
    end
    add_stim(1'b1, 32'ha3, 3'd2, 64'h1111_2222_3333_4444, 1'b0);  // Misaligned.
    add_stim(1'b1, 32'ha7, 3'd1, 64'h5555_6666_7777_8899, 1'b1);
    add_stim(1'b1, 32'hb5, 3'd3, 64'hfeed_face_cafe_d00d, 1'b0);
    add_stim(1'b0, 32'ha0, 3'd3, '0, 1'b0);
    add_stim(1'b0, 32'hb3, 3'd3, '0, 1'b0);
    add_stim(1'b1, 32'h800, 3'd3, 64'hbad0_bad0_bad0_bad0, 1'b0);  // Out of range.
    add_stim(1'b0, 32'h800, 3'd3, '0, 1'b1);
    add_stim(1'b1, 32'h1000_0004, 3'd2, 64'h0bad_0bad, 1'b0);
    add_stim(1'b0, 32'hffff_fff8, 3'd3, '0, 1'b0);
    add_stim(1'b0, 32'h0, 3'd3, '0, 1'b0);    // Word 0 shares index bits with both.
    add_stim(1'b0, 32'h7f8, 3'd3, '0, 1'b0);  // Last word in range.
  endtask

  task automatic build_random(input int count);
    logic [31:0] r;
    logic [31:0] d_hi;
    logic [31:0] d_lo;
    logic [31:0] addr;
    for (int i = 0; i < count; i++) begin
      r    = $random(seed);
      d_hi = $random(seed);
      d_lo = $random(seed);
      addr = {21'd0, r[10:0]};
      if (r[31:29] == 3'd0) addr = addr | 32'h800;  // About one in eight out of range.
      add_stim(r[14], addr, {1'b0, r[13:12]}, {d_hi, d_lo}, 1'b0);
    end
  endtask

  // ******************************
  // Response port and monitor
  // ******************************
  initial begin
    logic [31:0] r;
    forever begin
      @(posedge clk);
      #1;
      if (random_phase) begin
        r         = $random(seed);
        rsp_ready = r[0];
      end else if (stall_cycles > 0) begin
        rsp_ready = 1'b0;
        stall_cycles--;
      end else begin
        rsp_ready = 1'b1;
      end
    end
  end

  initial begin
    mem_rsp_t exp;
    forever begin
      @(negedge clk);
      if (arst_n && rsp_valid && rsp_ready) begin
        recv_count++;
        if (exp_q.size() == 0) begin
          other_errors++;
          $display("Response at %0t arrived with no request outstanding", $time);
        end else begin
          exp = exp_q.pop_front();
          check_rsp(rsp, exp, "response");
        end
      end
    end
  end

  // ******************************
  // Main sequence
  // ******************************
  initial begin
    int waited;
    req_valid    = 1'b0;
    req          = '0;
    rsp_ready    = 1'b0;
    arst_n       = 1'b0;
    seed         = 32'h54b5_aeb0;
    random_phase = 1'b0;
    stall_cycles = 0;
    sent_count   = 0;
    recv_count   = 0;
    value_errors = 0;
    other_errors = 0;
    repeat (16) @(posedge clk);
    #1;
    arst_n = 1'b1;
    @(negedge clk);
    check_flag(rsp_valid, 1'b0, "rsp_valid after reset");
    check_flag(req_ready, 1'b1, "req_ready after reset");
    @(posedge clk);
    #1;
    for (int i = 0; i < mem_words_lp; i++) begin
      send_req(make_req(1'b1, 32'(i * 8), 3'd3, fill_word(32'(i * 8))), 1'b0);
    end
    build_table();
    foreach (stim_q[i]) send_req(stim_q[i].req, stim_q[i].stall);
    stim_q.delete();
    build_random(random_reqs_lp);
    @(negedge clk);
    random_phase = 1'b1;
    @(posedge clk);
    #1;
    foreach (stim_q[i]) send_req(stim_q[i].req, stim_q[i].stall);
    waited = 0;
    while (exp_q.size() != 0) begin
      waited++;
      if (waited > wait_limit_lp) abort_run("timeout waiting for outstanding responses");
      @(negedge clk);
    end
    repeat (10) @(negedge clk);  // Room for any duplicate response to show up.
    check_count(recv_count, sent_count, "responses");
    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
